/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - files:
      - source/fetch_pkg.sv
      - source/fetch_attr_fifo.sv
      - source/ilocal_mem_unit.sv
      - source/ibus_unit.sv
      - source/fetch.sv
      - source/fetch_subsystem.sv
  - target: test
    files:
      - dv/fetch_subsystem_tb.sv

/* dv/fetch_stimulus.txt */
# mem  <local|bus> <word index hex> <value hex>
# test <name> <start pc hex, 0 continues from reset> <fetches> <hold mask hex, bit n = cycle n> <first ok>
mem local 0 00000013
mem local 1 00100093
mem local 2 00208113
mem local 3 00310193
mem local 9 00c0006f
mem local 40 fe010113
mem local 41 00812e23
mem local 42 02010413
mem local fd 00000297
mem local fe 0182a303
mem local ff 0000006f
mem bus 10 00500513
mem bus 11 00a00593
mem bus 12 00b50633
mem bus 80 40b50533
mem bus 81 00157593
test reset_local 0 8 0000 1
test bus_latency 00010040 10 0000 1
test redirect_flush 00001026 6 0000 1
test access_fault 00020003 4 0000 0
test hold_local 00001100 12 0ff0 1
test hold_bus 00010200 6 00f8 1
test region_boundary 000013f4 6 0000 1

/* dv/fetch_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem_tb
    import fetch_pkg::*;
();

    logic clk;
    logic rst;
    logic redirect;
    logic [31:0] redirect_pc;
    logic fetch_hold;
    imem_write_t imem_wr;
    ibus_req_t ibus_req;
    ibus_rsp_t ibus_rsp;
    fetch_result_t fetch_out;

    // Reference images of both regions
    logic [31:0] bus_words [IBUS_WORDS];
    logic [31:0] local_words [ILOCAL_WORDS];

    string test_name [$];
    logic [31:0] test_start [$];
    int test_count [$];
    logic [15:0] test_hold [$];
    logic test_ok [$];

    int error_count;
    int failed_tests;
    int watchdog_cycles;

    always #2 clk = ~clk;

    fetch_subsystem UUT (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_hold  (fetch_hold),
        .imem_wr     (imem_wr),
        .ibus_req    (ibus_req),
        .ibus_rsp    (ibus_rsp),
        .fetch_out   (fetch_out)
    );

    //////////////////////////////
    // Bus model acks 1 to 4 cycles after the request strobe
    initial begin : bus_model
        int delay;
        logic [31:0] addr;
        delay = $urandom(32'h91694db8);
        forever begin
            @(negedge clk);
            if (!rst && ibus_req.req) begin
                delay = 1 + int'($urandom % 4);
                addr = ibus_req.addr;
                if (!in_region(addr, IBUS_BASE, IBUS_WORDS) || addr[1:0] != 2'b00) begin
                    error_count++;
                    $display("Bus request to %h falls outside the bus region", addr);
                end
                repeat (delay) @(posedge clk);
                #0.5;
                ibus_rsp.ack = 1'b1;
                ibus_rsp.data = bus_words[(addr - IBUS_BASE) >> 2];
                @(posedge clk);
                #0.5;
                ibus_rsp.ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run timed out after %0d cycles before all tests finished", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////
    // Helpers

    // Drive point of the next cycle
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic load_local(input logic [7:0] idx, input logic [31:0] data);
        next_cycle();
        imem_wr.we = 1'b1;
        imem_wr.addr = idx;
        imem_wr.data = data;
        local_words[idx] = data;
    endtask

    function automatic bit in_region(input logic [31:0] pc, input logic [31:0] base,
                                     input int words);
        return (pc >= base) && (pc < base + 32'(4 * words));
    endfunction

    function automatic fetch_result_t predict(input logic [31:0] pc);
        fetch_result_t r;
        r.valid = 1'b1;
        r.pc = pc;
        r.ok = 1'b1;
        if (in_region(pc, ILOCAL_BASE, ILOCAL_WORDS)) begin
            r.instruction = local_words[(pc - ILOCAL_BASE) >> 2];
        end else if (in_region(pc, IBUS_BASE, IBUS_WORDS)) begin
            r.instruction = bus_words[(pc - IBUS_BASE) >> 2];
        end else begin
            // Unmapped address faults
            r.instruction = 32'd0;
            r.ok = 1'b0;
        end
        return r;
    endfunction

    task automatic check_result(input string name, input fetch_result_t expected,
                                input fetch_result_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s: expected pc=%h instr=%h ok=%b, actual pc=%h instr=%h ok=%b",
                     name, expected.pc, expected.instruction, expected.ok,
                     actual.pc, actual.instruction, actual.ok);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            error_count++;
            $display("ERROR %s: expected %0d results, actual %0d", name, expected, actual);
        end
    endtask

    //////////////////////////////
    // One test record
    task automatic run_test(input int t);
        logic [31:0] pc;
        int cyc;
        int got;
        int in_hold;
        int errors_before;
        fetch_result_t expected;
        errors_before = error_count;
        cyc = 0;
        got = 0;
        in_hold = 0;
        pc = RESET_VEC;
        if (test_start[t] != 32'd0) begin
            pc = {test_start[t][31:2], 2'b00};
            // Old path runs briefly so the redirect has work to flush
            next_cycle();
            fetch_hold = 1'b0;
            repeat (2) next_cycle();
            redirect = 1'b1;
            redirect_pc = test_start[t];
            // Completions in the redirect cycle still belong to the old path
            @(negedge clk);
            if (fetch_out.valid) begin
                error_count++;
                $display("%s: an old path result for pc %h came out in the redirect cycle",
                         test_name[t], fetch_out.pc);
            end
        end
        while (got < test_count[t] && cyc < 16 * test_count[t] + 16) begin
            next_cycle();
            redirect = 1'b0;
            fetch_hold = (cyc < 16) ? test_hold[t][cyc] : 1'b0;
            @(negedge clk);
            if (fetch_out.valid) begin
                expected = predict(pc);
                if (got == 0) begin
                    expected.ok = test_ok[t];
                end
                check_result(test_name[t], expected, fetch_out);
                if (fetch_hold) begin
                    in_hold++;
                end
                pc = pc + 32'd4;
                got++;
            end
            cyc++;
        end
        // Park fetch and let the tail of the stream drain
        next_cycle();
        fetch_hold = 1'b1;
        repeat (12) next_cycle();
        check_count(test_name[t], test_count[t], got);
        if (in_hold > ATTR_DEPTH) begin
            error_count++;
            $display("%s: %0d results arrived during hold, more than could be in flight",
                     test_name[t], in_hold);
        end
        if (error_count != errors_before) begin
            failed_tests++;
        end
        $display("%s: %s, %0d of %0d results", test_name[t],
                 (error_count == errors_before) ? "passed" : "failed", got, test_count[t]);
    endtask

    //////////////////////////////
    initial begin : main
        int fd;
        int n;
        int total;
        string line;
        string tag;
        string field;
        logic [31:0] a;
        logic [31:0] b;
        int cnt;
        logic [15:0] hold;
        int ok;
        clk = 1'b0;
        rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = '0;
        fetch_hold = 1'b1;
        imem_wr = '0;
        ibus_rsp = '0;
        error_count = 0;
        failed_tests = 0;
        watchdog_cycles = 0;
        for (int i = 0; i < IBUS_WORDS; i++) begin
            bus_words[i] = 32'hB5A0_0000 ^ (IBUS_BASE + 32'(4 * i));
        end
        repeat (3) next_cycle();
        rst = 1'b0;
        for (int i = 0; i < ILOCAL_WORDS; i++) begin
            load_local(8'(i), 32'h6C00_0000 ^ (ILOCAL_BASE + 32'(4 * i)));
        end

        fd = $fopen("dv/fetch_stimulus.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the stimulus file dv/fetch_stimulus.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s", tag);
                if (n == 1 && tag == "mem") begin
                    n = $sscanf(line, "%s %s %h %h", tag, field, a, b);
                    if (field == "local") begin
                        load_local(a[7:0], b);
                    end else begin
                        bus_words[a] = b;
                    end
                end else if (n == 1 && tag == "test") begin
                    n = $sscanf(line, "%s %s %h %d %h %d", tag, field, a, cnt, hold, ok);
                    test_name.push_back(field);
                    test_start.push_back(a);
                    test_count.push_back(cnt);
                    test_hold.push_back(hold);
                    test_ok.push_back(ok != 0);
                end
            end
            $fclose(fd);
        end
        next_cycle();
        imem_wr = '0;

        total = 0;
        foreach (test_count[i]) begin
            total += test_count[i];
        end
        watchdog_cycles = 40 * total;
        if (test_name.size() == 0) begin
            error_count++;
            $display("No test records were found in the stimulus file");
        end
        foreach (test_name[i]) begin
            run_test(i);
        end
        $display("%0d tests run, %0d failed, %0d errors", test_name.size(), failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* fetch_subsystem.f */
source/fetch_pkg.sv
source/fetch_attr_fifo.sv
source/ilocal_mem_unit.sv
source/ibus_unit.sv
source/fetch.sv
source/fetch_subsystem.sv
dv/fetch_subsystem_tb.sv

/* source/fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          redirect,
    input  logic [31:0]   redirect_pc,
    input  logic          fetch_hold,

    output source_req_t   local_req,
    output source_req_t   bus_req,
    input  source_rsp_t   local_rsp,
    input  source_rsp_t   bus_rsp,

    output fetch_result_t fetch_out
);

    logic [31:0] pc;
    logic [31:0] pc_plus_4;
    logic [31:0] next_pc;

    logic [31:0] local_offset;
    logic [31:0] bus_offset;
    logic local_match;
    logic bus_match;
    logic address_valid;

    logic [NUM_SOURCES-1:0] unit_ready;
    logic [NUM_SOURCES-1:0] unit_data_valid;
    logic [31:0] unit_data [NUM_SOURCES];

    logic issue;
    logic complete;

    fetch_attr_t attr_in;
    fetch_attr_t attr_head;
    logic attr_valid;
    logic attr_full;

    logic [$clog2(ATTR_DEPTH+1)-1:0] inflight_count;
    logic [$clog2(ATTR_DEPTH+1)-1:0] inflight_count_next;
    logic [$clog2(ATTR_DEPTH+1)-1:0] flush_count;

    //////////////////////////////
    // PC

    // Redirect wins over sequential fetch
    assign pc_plus_4 = pc + 32'd4;
    assign next_pc = redirect ? {redirect_pc[31:2], 2'b00} : pc_plus_4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (redirect | issue) begin
            pc <= next_pc;
        end
    end

    // Region decode
    // Offsets wrap below a base so one compare covers each region
    assign local_offset = pc - ILOCAL_BASE;
    assign bus_offset = pc - IBUS_BASE;
    assign local_match = (local_offset < 32'(4 * ILOCAL_WORDS));
    assign bus_match = (bus_offset < 32'(4 * IBUS_WORDS));
    assign address_valid = local_match | bus_match;

    //////////////////////////////
    // Source gathering
    assign unit_ready[SRC_LOCAL] = local_rsp.ready;
    assign unit_ready[SRC_BUS] = bus_rsp.ready;
    assign unit_data_valid[SRC_LOCAL] = local_rsp.data_valid;
    assign unit_data_valid[SRC_BUS] = bus_rsp.data_valid;
    assign unit_data[SRC_LOCAL] = local_rsp.data;
    assign unit_data[SRC_BUS] = bus_rsp.data;

    // Issue control
    assign issue = (&unit_ready) & ~attr_full & ~fetch_hold & ~redirect;

    // Unmapped addresses strobe no source
    assign local_req.new_request = issue & local_match;
    assign local_req.addr = pc;
    assign bus_req.new_request = issue & bus_match;
    assign bus_req.addr = pc;

    //////////////////////////////
    // Request attributes kept oldest first
    assign attr_in.pc = pc;
    assign attr_in.address_valid = address_valid;
    assign attr_in.source_id = bus_match ? 1'(SRC_BUS) : 1'(SRC_LOCAL);

    fetch_attr_fifo attr_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (issue),
        .data_in  (attr_in),
        .pop      (complete),
        .data_out (attr_head),
        .valid    (attr_valid),
        .full     (attr_full)
    );

    // Faulting requests retire as soon as they reach the head
    assign complete = attr_valid &
                      (attr_head.address_valid ? unit_data_valid[attr_head.source_id] : 1'b1);

    //////////////////////////////
    // In-flight and flush counting
    assign inflight_count_next = inflight_count + issue - complete;

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_count <= '0;
        end else begin
            inflight_count <= inflight_count_next;
        end
    end

    // Requests still outstanding at a redirect belong to the old path
    always_ff @(posedge clk) begin
        if (rst) begin
            flush_count <= '0;
        end else if (redirect) begin
            flush_count <= inflight_count_next;
        end else if (complete && flush_count != '0) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    //////////////////////////////
    // Result forwarding

    // Completion in the redirect cycle is also old path
    assign fetch_out.valid = complete & (flush_count == '0) & ~redirect;
    assign fetch_out.pc = attr_head.pc;
    assign fetch_out.instruction = attr_head.address_valid ?
                                   unit_data[attr_head.source_id] : 32'd0;
    assign fetch_out.ok = attr_head.address_valid;

endmodule

`default_nettype wire

/* source/fetch_attr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_attr_fifo
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  fetch_attr_t data_in,
    input  logic        pop,
    output fetch_attr_t data_out,
    output logic        valid,
    output logic        full
);

    fetch_attr_t entries [ATTR_DEPTH];
    logic [$clog2(ATTR_DEPTH)-1:0] rd_ptr;
    logic [$clog2(ATTR_DEPTH)-1:0] wr_ptr;
    logic [$clog2(ATTR_DEPTH+1)-1:0] count;

    // Storage written at the tail
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= data_in;
        end
    end

    // Pointer and occupancy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (int'(wr_ptr) == ATTR_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (int'(rd_ptr) == ATTR_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry is visible without a pop
    assign data_out = entries[rd_ptr];
    assign valid = (count != '0);
    assign full = (int'(count) == ATTR_DEPTH);

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    //////////////////////////////
    // Memory map

    localparam logic [31:0] RESET_VEC = 32'h0000_1000;

    localparam logic [31:0] ILOCAL_BASE = 32'h0000_1000;
    localparam int ILOCAL_WORDS = 256;

    localparam logic [31:0] IBUS_BASE = 32'h0001_0000;
    localparam int IBUS_WORDS = 1024;

    // Outstanding requests tracked by fetch
    localparam int ATTR_DEPTH = 2;

    // Fetch source indices
    localparam int NUM_SOURCES = 2;
    localparam int SRC_LOCAL = 0;
    localparam int SRC_BUS = 1;

    //////////////////////////////
    // Fetch side

    typedef struct packed {
        logic [31:0] pc;
        logic address_valid;
        logic source_id;
    } fetch_attr_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] instruction;
        logic ok;
    } fetch_result_t;

    //////////////////////////////
    // Memory load and bus traffic

    typedef struct packed {
        logic we;
        logic [7:0] addr;
        logic [31:0] data;
    } imem_write_t;

    typedef struct packed {
        logic req;
        logic [31:0] addr;
    } ibus_req_t;

    typedef struct packed {
        logic ack;
        logic [31:0] data;
    } ibus_rsp_t;

    // Common link between fetch and each source
    typedef struct packed {
        logic new_request;
        logic [31:0] addr;
    } source_req_t;

    typedef struct packed {
        logic ready;
        logic data_valid;
        logic [31:0] data;
    } source_rsp_t;

endpackage

`default_nettype wire

/* source/fetch_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_subsystem
    import fetch_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          redirect,
    input  logic [31:0]   redirect_pc,
    input  logic          fetch_hold,

    input  imem_write_t   imem_wr,

    output ibus_req_t     ibus_req,
    input  ibus_rsp_t     ibus_rsp,

    output fetch_result_t fetch_out
);

    // Links between fetch and its two sources
    source_req_t local_src_req;
    source_rsp_t local_src_rsp;
    source_req_t bus_src_req;
    source_rsp_t bus_src_rsp;

    fetch fetch_core (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_hold  (fetch_hold),
        .local_req   (local_src_req),
        .bus_req     (bus_src_req),
        .local_rsp   (local_src_rsp),
        .bus_rsp     (bus_src_rsp),
        .fetch_out   (fetch_out)
    );

    //////////////////////////////
    // Fetch sources
    ilocal_mem_unit local_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (local_src_req),
        .rsp     (local_src_rsp),
        .imem_wr (imem_wr)
    );

    ibus_unit bus_unit (
        .clk     (clk),
        .rst     (rst),
        .req     (bus_src_req),
        .rsp     (bus_src_rsp),
        .bus_req (ibus_req),
        .bus_rsp (ibus_rsp)
    );

endmodule

`default_nettype wire

/* source/ibus_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ibus_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  source_req_t req,
    output source_rsp_t rsp,
    output ibus_req_t   bus_req,
    input  ibus_rsp_t   bus_rsp
);

    logic busy;
    logic req_strobe;
    logic [31:0] req_addr;

    //////////////////////////////
    // Outstanding request tracking

    // Busy from the request until its ack
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (req.new_request) begin
            busy <= 1'b1;
        end else if (bus_rsp.ack) begin
            busy <= 1'b0;
        end
    end

    // Bus strobe lags the fetch request by a cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            req_strobe <= 1'b0;
        end else begin
            req_strobe <= req.new_request;
        end
    end

    always_ff @(posedge clk) begin
        if (req.new_request) begin
            req_addr <= req.addr;
        end
    end

    //////////////////////////////
    // Bus side
    assign bus_req.req = req_strobe;
    assign bus_req.addr = req_addr;

    // Fetch side
    // Stray acks outside a request are ignored
    assign rsp.ready = ~busy;
    assign rsp.data_valid = busy & bus_rsp.ack;
    assign rsp.data = bus_rsp.data;

endmodule

`default_nettype wire

/* source/ilocal_mem_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module ilocal_mem_unit
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  source_req_t req,
    output source_rsp_t rsp,
    input  imem_write_t imem_wr
);

    logic [31:0] ram [ILOCAL_WORDS];
    logic [31:0] byte_offset;
    logic [$clog2(ILOCAL_WORDS)-1:0] rd_index;
    logic [31:0] rd_data;
    logic rd_valid;

    // Word index within the local region
    assign byte_offset = req.addr - ILOCAL_BASE;
    assign rd_index = byte_offset[2 +: $clog2(ILOCAL_WORDS)];

    //////////////////////////////
    // RAM with a load port and a fetch read port
    always_ff @(posedge clk) begin
        if (imem_wr.we) begin
            ram[imem_wr.addr] <= imem_wr.data;
        end
        if (req.new_request) begin
            rd_data <= ram[rd_index];
        end
    end

    // Data comes back one cycle after the request
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= req.new_request;
        end
    end

    // Fixed latency means it can always take a request
    assign rsp.ready = 1'b1;
    assign rsp.data_valid = rd_valid;
    assign rsp.data = rd_data;

endmodule

`default_nettype wire
